//--- mem_pkg.sv
// Shared data memory definitions

package mem_pkg;

   localparam int ADDR_W  = 8;            // Word address, 256 words
   localparam int DATA_W  = 32;
   localparam int COL_W   = 8;            // One byte lane
   localparam int NUM_COL = DATA_W / COL_W;
   localparam int BADDR_W = ADDR_W + 2;   // Byte address
   localparam int CNT_W   = ADDR_W + 1;   // Word count up to 256

   // Load/store access size
   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } size_e;

   // Block engine operation
   typedef enum logic {
      OP_FILL = 1'b0,
      OP_SUM  = 1'b1
   } op_e;

   // One memory word, seen whole or lane by lane
   typedef union packed {
      logic [DATA_W-1:0]               word;
      logic [NUM_COL-1:0][COL_W-1:0]   lanes;
   } mem_word_u;

   // Port A request
   typedef struct packed {
      logic                we;        // Store when set
      size_e               size;
      logic                sign_ext;  // Loads only
      logic [BADDR_W-1:0]  addr;
      logic [DATA_W-1:0]   wdata;     // Right aligned
   } lsu_req_t;

   // Port B command
   typedef struct packed {
      op_e                 op;
      logic [ADDR_W-1:0]   base;
      logic [CNT_W-1:0]    count;     // 1 to 256 words
      logic [DATA_W-1:0]   pattern;
   } eng_cmd_t;

endpackage

//--- ram_dp.sv
// Dual-port column RAM, read-first

`timescale 1ns/1ns

module ram_dp #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 8
) (
   input  logic              clk_i,

   // Port A
   input  logic              enA_i,
   input  logic              weA_i,
   input  logic [ADDR_W-1:0] addrA_i,
   input  logic [DATA_W-1:0] dA_i,
   output logic [DATA_W-1:0] dA_o,

   // Port B
   input  logic              enB_i,
   input  logic              weB_i,
   input  logic [ADDR_W-1:0] addrB_i,
   input  logic [DATA_W-1:0] dB_i,
   output logic [DATA_W-1:0] dB_o
);

   logic [DATA_W-1:0] mem [0:(2**ADDR_W)-1];

   // Both ports in one process
   // Reads return the contents from before this edge's write
   always_ff @(posedge clk_i) begin
      if (enA_i) begin
         if (weA_i) begin
            mem[addrA_i] <= dA_i;
         end
         dA_o <= mem[addrA_i];   // Old data
      end
      if (enB_i) begin
         if (weB_i) begin
            mem[addrB_i] <= dB_i;   // Same-word collision undefined
         end
         dB_o <= mem[addrB_i];
      end
   end

endmodule

//--- ram_dp_be.sv
// Byte-enable dual-port RAM
// One column RAM per byte lane

`timescale 1ns/1ns

module ram_dp_be import mem_pkg::*; (
   input  logic               clk_i,

   // Port A
   input  logic               enA_i,
   input  logic [NUM_COL-1:0] weA_i,
   input  logic [ADDR_W-1:0]  addrA_i,
   input  logic [DATA_W-1:0]  dA_i,
   output logic [DATA_W-1:0]  dA_o,

   // Port B
   input  logic               enB_i,
   input  logic [NUM_COL-1:0] weB_i,
   input  logic [ADDR_W-1:0]  addrB_i,
   input  logic [DATA_W-1:0]  dB_i,
   output logic [DATA_W-1:0]  dB_o
);

   for (genvar c = 0; c < NUM_COL; c++) begin : g_col
      ram_dp #(
         .DATA_W (COL_W),
         .ADDR_W (ADDR_W)
      ) u_col (
         .clk_i   (clk_i),
         .enA_i   (enA_i),                   // Shared enable and address
         .weA_i   (weA_i[c]),
         .addrA_i (addrA_i),
         .dA_i    (dA_i[c*COL_W +: COL_W]),
         .dA_o    (dA_o[c*COL_W +: COL_W]),
         .enB_i   (enB_i),
         .weB_i   (weB_i[c]),
         .addrB_i (addrB_i),
         .dB_i    (dB_i[c*COL_W +: COL_W]),
         .dB_o    (dB_o[c*COL_W +: COL_W])
      );
   end

endmodule

//--- lsu_align.sv
// Port A load/store aligner

`timescale 1ns/1ns

module lsu_align import mem_pkg::*; (
   input  logic               clk_i,
   input  logic               rst_n_i,

   // Request side
   input  logic               req_valid_i,
   input  lsu_req_t           req_i,

   // RAM port
   output logic               ram_en_o,
   output logic [NUM_COL-1:0] ram_be_o,
   output logic [ADDR_W-1:0]  ram_addr_o,
   output logic [DATA_W-1:0]  ram_wdata_o,
   input  logic [DATA_W-1:0]  ram_rdata_i,

   // Load response
   output logic [DATA_W-1:0]  rdata_o,
   output logic               rdata_valid_o
);

   logic [1:0]           req_off;
   logic [NUM_COL-1:0]   be;
   mem_word_u            wr_word;

   // Load state held for the RAM read cycle
   logic                 ld_valid_q;
   logic [1:0]           ld_off_q;
   size_e                ld_size_q;
   logic                 ld_sign_q;

   mem_word_u            rd_word;
   logic [COL_W-1:0]     lane_b;
   logic [2*COL_W-1:0]   lane_h;

   assign req_off    = req_i.addr[1:0];
   assign ram_en_o   = req_valid_i;
   assign ram_addr_o = req_i.addr[BADDR_W-1:2];

   // Lane selection
   always_comb begin
      case (req_i.size)
         SZ_BYTE: be = NUM_COL'(1) << req_off;
         SZ_HALF: be = req_off[1] ? 4'b1100 : 4'b0011;   // Bit 0 ignored
         default: be = '1;
      endcase
   end

   assign ram_be_o = (req_valid_i && req_i.we) ? be : '0;

   // Store data copied into every lane it could land in
   always_comb begin
      wr_word.word = req_i.wdata;
      case (req_i.size)
         SZ_BYTE: begin
            for (int i = 0; i < NUM_COL; i++) begin
               wr_word.lanes[i] = req_i.wdata[COL_W-1:0];
            end
         end
         SZ_HALF: begin
            for (int i = 0; i < NUM_COL; i++) begin
               wr_word.lanes[i] = req_i.wdata[(i % 2)*COL_W +: COL_W];
            end
         end
         default: ;
      endcase
   end

   assign ram_wdata_o = wr_word.word;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ld_valid_q <= 1'b0;
      end else begin
         ld_valid_q <= req_valid_i && !req_i.we;
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_valid_i) begin
         ld_off_q  <= req_off;
         ld_size_q <= req_i.size;
         ld_sign_q <= req_i.sign_ext;
      end
   end

   // Pick lanes from the returned word and extend
   always_comb begin
      rd_word.word = ram_rdata_i;
      lane_b = rd_word.lanes[ld_off_q];
      lane_h = {rd_word.lanes[{ld_off_q[1], 1'b1}], rd_word.lanes[{ld_off_q[1], 1'b0}]};
      case (ld_size_q)
         SZ_BYTE: rdata_o = {{(DATA_W-COL_W){ld_sign_q & lane_b[COL_W-1]}}, lane_b};
         SZ_HALF: rdata_o = {{(DATA_W-2*COL_W){ld_sign_q & lane_h[2*COL_W-1]}}, lane_h};
         default: rdata_o = rd_word.word;
      endcase
   end

   assign rdata_valid_o = ld_valid_q;

endmodule

//--- blk_engine.sv
// Port B block engine, fill and checksum

`timescale 1ns/1ns

module blk_engine import mem_pkg::*; (
   input  logic               clk_i,
   input  logic               rst_n_i,

   // Command side
   input  logic               start_i,
   input  eng_cmd_t           cmd_i,

   // RAM port
   output logic               ram_en_o,
   output logic [NUM_COL-1:0] ram_be_o,
   output logic [ADDR_W-1:0]  ram_addr_o,
   output logic [DATA_W-1:0]  ram_wdata_o,
   input  logic [DATA_W-1:0]  ram_rdata_i,

   // Status
   output logic               busy_o,
   output logic               done_o,
   output logic [DATA_W-1:0]  sum_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_RUN,     // One access per cycle
      ST_DRAIN    // Reads still coming back
   } state_e;

   state_e               state_q;
   op_e                  op_q;
   logic [ADDR_W-1:0]    addr_q;
   logic [CNT_W-1:0]     remain_q;
   logic [DATA_W-1:0]    pattern_q;
   logic                 last_issue;

   // Read pipeline, bit 0 marks RAM output valid, bit 1 marks rdata_q valid
   logic [1:0]           vld_q;
   logic [DATA_W-1:0]    rdata_q;
   logic [DATA_W-1:0]    sum_q;
   logic                 done_q;

   assign last_issue = (remain_q <= CNT_W'(1));   // Count of 0 acts as 1

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q  <= ST_IDLE;
         op_q     <= OP_FILL;
         addr_q   <= '0;
         remain_q <= '0;
         vld_q    <= '0;
         sum_q    <= '0;
         done_q   <= 1'b0;
      end else begin
         done_q <= 1'b0;
         vld_q  <= {vld_q[0], (state_q == ST_RUN) && (op_q == OP_SUM)};
         if (vld_q[1]) begin
            sum_q <= sum_q + rdata_q;   // Wraps at 32 bits
         end
         case (state_q)
            ST_IDLE: begin
               if (start_i) begin
                  state_q  <= ST_RUN;
                  op_q     <= cmd_i.op;
                  addr_q   <= cmd_i.base;
                  remain_q <= cmd_i.count;
                  sum_q    <= '0;
               end
            end
            ST_RUN: begin
               addr_q   <= addr_q + 1'b1;
               remain_q <= remain_q - 1'b1;
               if (last_issue) begin
                  if (op_q == OP_FILL) begin
                     state_q <= ST_IDLE;
                     done_q  <= 1'b1;
                  end else begin
                     state_q <= ST_DRAIN;
                  end
               end
            end
            ST_DRAIN: begin
               // Last word is being added this cycle
               if (vld_q[1] && !vld_q[0]) begin
                  state_q <= ST_IDLE;
                  done_q  <= 1'b1;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if ((state_q == ST_IDLE) && start_i) begin
         pattern_q <= cmd_i.pattern;
      end
      rdata_q <= ram_rdata_i;
   end

   assign ram_en_o    = (state_q == ST_RUN);
   assign ram_be_o    = (ram_en_o && (op_q == OP_FILL)) ? '1 : '0;   // Sum only reads
   assign ram_addr_o  = addr_q;
   assign ram_wdata_o = pattern_q;

   assign busy_o = (state_q != ST_IDLE);
   assign done_o = done_q;
   assign sum_o  = sum_q;

endmodule

//--- dual_mem_top.sv
// Dual-port data memory top level

`timescale 1ns/1ns

module dual_mem_top import mem_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_n_i,

   // Port A, load/store
   input  logic              req_valid_i,
   input  lsu_req_t          req_i,
   output logic [DATA_W-1:0] rdata_o,
   output logic              rdata_valid_o,

   // Port B, block engine
   input  logic              start_i,
   input  eng_cmd_t          cmd_i,
   output logic              busy_o,
   output logic              done_o,
   output logic [DATA_W-1:0] sum_o
);

   logic               a_en;
   logic [NUM_COL-1:0] a_be;
   logic [ADDR_W-1:0]  a_addr;
   logic [DATA_W-1:0]  a_wdata;
   logic [DATA_W-1:0]  a_rdata;

   logic               b_en;
   logic [NUM_COL-1:0] b_be;
   logic [ADDR_W-1:0]  b_addr;
   logic [DATA_W-1:0]  b_wdata;
   logic [DATA_W-1:0]  b_rdata;

   lsu_align u_lsu (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .req_valid_i   (req_valid_i),
      .req_i         (req_i),
      .ram_en_o      (a_en),
      .ram_be_o      (a_be),
      .ram_addr_o    (a_addr),
      .ram_wdata_o   (a_wdata),
      .ram_rdata_i   (a_rdata),
      .rdata_o       (rdata_o),
      .rdata_valid_o (rdata_valid_o)
   );

   blk_engine u_eng (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .start_i     (start_i),
      .cmd_i       (cmd_i),
      .ram_en_o    (b_en),
      .ram_be_o    (b_be),
      .ram_addr_o  (b_addr),
      .ram_wdata_o (b_wdata),
      .ram_rdata_i (b_rdata),
      .busy_o      (busy_o),
      .done_o      (done_o),
      .sum_o       (sum_o)
   );

   ram_dp_be u_ram (
      .clk_i   (clk_i),
      .enA_i   (a_en),
      .weA_i   (a_be),
      .addrA_i (a_addr),
      .dA_i    (a_wdata),
      .dA_o    (a_rdata),
      .enB_i   (b_en),
      .weB_i   (b_be),
      .addrB_i (b_addr),
      .dB_i    (b_wdata),
      .dB_o    (b_rdata)
   );

endmodule

//--- tb_dual_mem.sv
// Testbench for the dual-port data memory

`timescale 1ns/1ns

module tb_dual_mem import mem_pkg::*; ();

   localparam int MAX_TESTS = 48;
   localparam int TIMEOUT   = 400;   // Cycles per wait

   typedef enum logic [1:0] {
      K_STORE,
      K_LOAD,
      K_FILL,
      K_SUM
   } kind_e;

   typedef struct {
      string       name;
      kind_e       kind;
      size_e       size;
      logic        sign;
      int          addr;         // Byte address on port A, word base on port B
      logic [31:0] data;         // Store data or fill pattern
      int          count;
      logic        busy_start;   // Extra start while busy
      logic [31:0] exp;
   } test_t;

   logic              clk_i;
   logic              rst_n_i;
   logic              req_valid_i;
   lsu_req_t          req_i;
   logic [DATA_W-1:0] rdata_o;
   logic              rdata_valid_o;
   logic              start_i;
   eng_cmd_t          cmd_i;
   logic              busy_o;
   logic              done_o;
   logic [DATA_W-1:0] sum_o;

   test_t      tbl [0:MAX_TESTS-1];
   int         ntests;
   int         seed;
   int         errors;
   int         n_pass;
   int         n_fail;
   logic [7:0] shadow [0:(1<<BADDR_W)-1];   // Byte image of the RAM

   dual_mem_top uut (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .req_valid_i   (req_valid_i),
      .req_i         (req_i),
      .rdata_o       (rdata_o),
      .rdata_valid_o (rdata_valid_o),
      .start_i       (start_i),
      .cmd_i         (cmd_i),
      .busy_o        (busy_o),
      .done_o        (done_o),
      .sum_o         (sum_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected) begin
         $display("MISMATCH %s expected %08h actual %08h", name, expected, actual);
         errors++;
      end
   endtask

   // Shadow memory model
   task automatic write_bytes(input size_e size, input int addr, input logic [31:0] data);
      case (size)
         SZ_BYTE: shadow[addr] = data[7:0];
         SZ_HALF: begin
            shadow[addr & ~1]       = data[7:0];
            shadow[(addr & ~1) + 1] = data[15:8];
         end
         default: begin
            for (int j = 0; j < 4; j++) begin
               shadow[(addr & ~3) + j] = data[8*j +: 8];
            end
         end
      endcase
   endtask

   function automatic logic [31:0] read_word(input int waddr);
      int b;
      b = (waddr % 256) * 4;
      read_word = {shadow[b+3], shadow[b+2], shadow[b+1], shadow[b]};
   endfunction

   function automatic logic [31:0] expect_load(input size_e size, input logic sign,
                                               input int addr);
      logic [7:0]  b;
      logic [15:0] h;
      case (size)
         SZ_BYTE: begin
            b = shadow[addr];
            expect_load = {{24{sign & b[7]}}, b};
         end
         SZ_HALF: begin
            h = {shadow[(addr & ~1) + 1], shadow[addr & ~1]};   // Bit 0 ignored
            expect_load = {{16{sign & h[15]}}, h};
         end
         default: expect_load = read_word(addr / 4);
      endcase
   endfunction

   task automatic fill_words(input int base, input int count, input logic [31:0] pattern);
      for (int i = 0; i < count; i++) begin
         write_bytes(SZ_WORD, ((base + i) % 256) * 4, pattern);
      end
   endtask

   function automatic logic [31:0] sum_words(input int base, input int count);
      logic [31:0] acc;
      acc = '0;
      for (int i = 0; i < count; i++) begin
         acc += read_word(base + i);   // Wraps at 32 bits
      end
      sum_words = acc;
   endfunction

   // One port A request, waits for the load response
   task automatic lsu_access(input test_t t, output logic [31:0] rdata, output int lat);
      req_valid_i    = 1'b1;
      req_i.we       = (t.kind == K_STORE);
      req_i.size     = t.size;
      req_i.sign_ext = t.sign;
      req_i.addr     = BADDR_W'(t.addr);
      req_i.wdata    = t.data;
      @(negedge clk_i);
      req_valid_i = 1'b0;
      rdata = '0;
      lat = 1;
      if (t.kind == K_LOAD) begin
         while (!rdata_valid_o && lat < TIMEOUT) begin
            @(negedge clk_i);
            lat++;
         end
         if (!rdata_valid_o) begin
            $display("ERROR %s: no load response within %0d cycles", t.name, TIMEOUT);
            errors++;
         end
         rdata = rdata_o;
      end else begin
         check({t.name, "_noresp"}, 32'd0, 32'(rdata_valid_o));   // Stores give no response
      end
   endtask

   // One engine command, counts done pulses after completion
   task automatic run_engine(input test_t t, output logic [31:0] sum, output int pulses);
      int n;
      cmd_i.op      = (t.kind == K_SUM) ? OP_SUM : OP_FILL;
      cmd_i.base    = ADDR_W'(t.addr);
      cmd_i.count   = CNT_W'(t.count);
      cmd_i.pattern = t.data;
      start_i = 1'b1;
      @(negedge clk_i);
      start_i = 1'b0;
      check({t.name, "_busy"}, 32'd1, 32'(busy_o));
      if (t.busy_start) begin
         // Would overwrite the guard words if taken
         cmd_i.op      = OP_FILL;
         cmd_i.base    = 8'h70;
         cmd_i.count   = 9'd2;
         cmd_i.pattern = 32'hDEAD_BEEF;
         start_i = 1'b1;
         @(negedge clk_i);
         start_i = 1'b0;
      end
      n = 0;
      while (!done_o && n < TIMEOUT) begin
         @(negedge clk_i);
         n++;
      end
      sum = sum_o;
      pulses = 0;
      if (!done_o) begin
         $display("ERROR %s: engine never signalled done", t.name);
         errors++;
      end else begin
         check({t.name, "_idle"}, 32'd0, 32'(busy_o));
         for (int k = 0; k < 8; k++) begin
            if (done_o) begin
               pulses++;
            end
            @(negedge clk_i);
         end
      end
   endtask

   task automatic add_test(input string name, input kind_e kind, input size_e size,
                           input logic sign, input int addr, input logic [31:0] data,
                           input int count, input logic busy_start);
      tbl[ntests].name       = name;
      tbl[ntests].kind       = kind;
      tbl[ntests].size       = size;
      tbl[ntests].sign       = sign;
      tbl[ntests].addr       = addr;
      tbl[ntests].data       = data;
      tbl[ntests].count      = count;
      tbl[ntests].busy_start = busy_start;
      tbl[ntests].exp        = '0;
      ntests++;
   endtask

   task automatic build_table();
      add_test("st_word_a",  K_STORE, SZ_WORD, 0, 'h010, $random(seed), 0, 0);
      add_test("ld_word_a",  K_LOAD,  SZ_WORD, 0, 'h010, 0, 0, 0);   // Read after write
      add_test("st_word_b",  K_STORE, SZ_WORD, 0, 'h020, $random(seed), 0, 0);
      add_test("st_byte_b1", K_STORE, SZ_BYTE, 0, 'h021, 32'h0000_0085, 0, 0);
      add_test("st_half_b2", K_STORE, SZ_HALF, 0, 'h022, 32'h0000_7F3C, 0, 0);
      add_test("ld_word_b",  K_LOAD,  SZ_WORD, 0, 'h020, 0, 0, 0);
      // Mixed sign bits per lane
      add_test("st_word_c",  K_STORE, SZ_WORD, 0, 'h030, 32'h8A7F_C341, 0, 0);
      add_test("ld_b0s",     K_LOAD,  SZ_BYTE, 1, 'h030, 0, 0, 0);
      add_test("ld_b1s",     K_LOAD,  SZ_BYTE, 1, 'h031, 0, 0, 0);
      add_test("ld_b2s",     K_LOAD,  SZ_BYTE, 1, 'h032, 0, 0, 0);
      add_test("ld_b3s",     K_LOAD,  SZ_BYTE, 1, 'h033, 0, 0, 0);
      add_test("ld_b0u",     K_LOAD,  SZ_BYTE, 0, 'h030, 0, 0, 0);
      add_test("ld_b1u",     K_LOAD,  SZ_BYTE, 0, 'h031, 0, 0, 0);
      add_test("ld_b2u",     K_LOAD,  SZ_BYTE, 0, 'h032, 0, 0, 0);
      add_test("ld_b3u",     K_LOAD,  SZ_BYTE, 0, 'h033, 0, 0, 0);
      add_test("ld_h0s",     K_LOAD,  SZ_HALF, 1, 'h030, 0, 0, 0);
      add_test("ld_h2s",     K_LOAD,  SZ_HALF, 1, 'h032, 0, 0, 0);
      add_test("ld_h0u",     K_LOAD,  SZ_HALF, 0, 'h030, 0, 0, 0);
      add_test("ld_h2u",     K_LOAD,  SZ_HALF, 0, 'h032, 0, 0, 0);
      add_test("ld_h3s",     K_LOAD,  SZ_HALF, 1, 'h033, 0, 0, 0);
      // Fill of words 0x50 to 0x55 with neighbours set first
      add_test("st_below",   K_STORE, SZ_WORD, 0, 'h13C, $random(seed), 0, 0);
      add_test("st_above",   K_STORE, SZ_WORD, 0, 'h158, $random(seed), 0, 0);
      add_test("fill_50",    K_FILL,  SZ_WORD, 0, 'h50,  $random(seed), 6, 0);
      add_test("ld_fill_lo", K_LOAD,  SZ_WORD, 0, 'h140, 0, 0, 0);
      add_test("ld_fill_md", K_LOAD,  SZ_WORD, 0, 'h148, 0, 0, 0);
      add_test("ld_fill_hi", K_LOAD,  SZ_WORD, 0, 'h154, 0, 0, 0);
      add_test("ld_below",   K_LOAD,  SZ_WORD, 0, 'h13C, 0, 0, 0);
      add_test("ld_above",   K_LOAD,  SZ_WORD, 0, 'h158, 0, 0, 0);
      // Checksum over words 0x60 to 0x64
      add_test("st_sum0",    K_STORE, SZ_WORD, 0, 'h180, $random(seed), 0, 0);
      add_test("st_sum1",    K_STORE, SZ_WORD, 0, 'h184, $random(seed), 0, 0);
      add_test("st_sum2",    K_STORE, SZ_WORD, 0, 'h188, $random(seed), 0, 0);
      add_test("st_sum3",    K_STORE, SZ_WORD, 0, 'h18C, $random(seed), 0, 0);
      add_test("st_sum4",    K_STORE, SZ_WORD, 0, 'h190, 32'hFFFF_FFF0, 0, 0);
      add_test("sum_60",     K_SUM,   SZ_WORD, 0, 'h60,  0, 5, 0);
      add_test("sum_single", K_SUM,   SZ_WORD, 0, 'h62,  0, 1, 0);
      // Start while busy, guard words at 0x70 and 0x71
      add_test("st_guard0",  K_STORE, SZ_WORD, 0, 'h1C0, $random(seed), 0, 0);
      add_test("st_guard1",  K_STORE, SZ_WORD, 0, 'h1C4, $random(seed), 0, 0);
      add_test("sum_busy",   K_SUM,   SZ_WORD, 0, 'h60,  0, 5, 1);
      add_test("fill_busy",  K_FILL,  SZ_WORD, 0, 'h51,  $random(seed), 3, 1);
      add_test("ld_refill",  K_LOAD,  SZ_WORD, 0, 'h148, 0, 0, 0);
      add_test("ld_guard0",  K_LOAD,  SZ_WORD, 0, 'h1C0, 0, 0, 0);
      add_test("ld_guard1",  K_LOAD,  SZ_WORD, 0, 'h1C4, 0, 0, 0);
   endtask

   task automatic apply_test(input int i);
      test_t       t;
      logic [31:0] actual;
      int          lat;
      int          pulses;
      int          err_before;
      t = tbl[i];
      err_before = errors;
      case (t.kind)
         K_STORE: begin
            write_bytes(t.size, t.addr, t.data);
            lsu_access(t, actual, lat);
         end
         K_LOAD: begin
            t.exp = expect_load(t.size, t.sign, t.addr);
            lsu_access(t, actual, lat);
            check(t.name, t.exp, actual);
            check({t.name, "_latency"}, 32'd1, 32'(lat));
         end
         K_FILL: begin
            fill_words(t.addr, t.count, t.data);
            run_engine(t, actual, pulses);
            check({t.name, "_done"}, 32'd1, 32'(pulses));
         end
         default: begin
            t.exp = sum_words(t.addr, t.count);
            run_engine(t, actual, pulses);
            check(t.name, t.exp, actual);
            check({t.name, "_done"}, 32'd1, 32'(pulses));
         end
      endcase
      tbl[i].exp = t.exp;
      if (errors == err_before) begin
         $display("%s: ok", t.name);
         n_pass++;
      end else begin
         $display("%s: FAIL", t.name);
         n_fail++;
      end
   endtask

   initial begin
      seed        = 8;
      errors      = 0;
      n_pass      = 0;
      n_fail      = 0;
      ntests      = 0;
      rst_n_i     = 1'b0;
      req_valid_i = 1'b0;
      req_i       = '0;
      start_i     = 1'b0;
      cmd_i       = '0;
      build_table();
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;
      // Outputs right after reset
      check("reset_rvalid", 32'd0, 32'(rdata_valid_o));
      check("reset_busy", 32'd0, 32'(busy_o));
      check("reset_done", 32'd0, 32'(done_o));
      check("reset_sum", 32'd0, sum_o);
      for (int i = 0; i < ntests; i++) begin
         apply_test(i);
      end
      $display("%0d tests, %0d passed, %0d failed, %0d errors", ntests, n_pass, n_fail, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- flist.f
mem_pkg.sv
ram_dp.sv
ram_dp_be.sv
lsu_align.sv
blk_engine.sv
dual_mem_top.sv
tb_dual_mem.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_dual_mem -o tb_dual_mem \
   && out=$(./obj_dir/tb_dual_mem) \
   && echo "$out" \
   && echo "$out" | grep -qx "Test passed" \
   || { echo "Simulation did not pass"; exit 1; }
